// ==== project.f ====
+incdir+.
wb_pkg.sv
wb_csr.sv
wb_flow_ctrl.sv
wb_r2w.sv
wb_echo_top.sv
tb_wb_echo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the echo engine testbench with verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 -f project.f \
    --top-module tb_wb_echo --Mdir "$OBJ_DIR" -o tb_wb_echo > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/tb_wb_echo" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Finished with errors" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== tb_wb_tests.svh ====
// register byte offset from its index
function automatic logic [31:0] reg_addr(input csr_idx_t idx);
    return 32'(idx) << 2;
endfunction

task automatic csr_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    do @(posedge clk); while (!s_awready);
    s_awvalid <= 1'b0;
    s_wdata   <= data;
    s_wstrb   <= 4'hF;
    s_wvalid  <= 1'b1;
    do @(posedge clk); while (!s_wready);
    s_wvalid <= 1'b0;
    s_bready <= 1'b1;
    do @(posedge clk); while (!s_bvalid);
    s_bready <= 1'b0;
    check_value("s_bresp", 64'(s_bresp), 64'd0);
endtask

task automatic csr_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    do @(posedge clk); while (!s_arready);
    s_arvalid <= 1'b0;
    s_rready  <= 1'b1;
    do @(posedge clk); while (!s_rvalid);
    s_rready <= 1'b0;
    data = s_rdata;
    check_value("s_rresp", 64'(s_rresp), 64'd0);
endtask

task automatic check_reg(input csr_idx_t idx, input logic [31:0] exp);
    logic [31:0] val;
    csr_read(reg_addr(idx), val);
    check_value($sformatf("csr %s", idx.name()), 64'(val), 64'(exp));
endtask

// one full copy that waits for irq and then checks the totals
task automatic run_copy(input logic [1:0] mps, input logic [31:0] base,
                        input logic [31:0] total, input int ar_lim, input int aw_lim);
    csr_write(reg_addr(csr_start), 32'd0);
    max_payload <= mps;
    exp_base        = base;
    exp_burst_bytes = 128 << mps;
    exp_bursts      = int'(total) / exp_burst_bytes;
    lim_ar          = ar_lim;
    lim_aw          = aw_lim;
    aw_cnt      = 0;
    w_burst     = 0;
    w_beat      = 0;
    w_total     = 0;
    b_cnt       = 0;
    irq_cnt     = 0;
    ar_total    = 0;
    max_ar_seen = 0;
    max_aw_seen = 0;
    csr_write(reg_addr(csr_base), base);
    csr_write(reg_addr(csr_total), total);
    csr_write(reg_addr(csr_pend_ar), 32'(ar_lim));
    csr_write(reg_addr(csr_pend_aw), 32'(aw_lim));
    csr_write(reg_addr(csr_start), 32'd1);
    wait (irq_cnt != 0);
    repeat (20) @(posedge clk); // room for a second pulse
    check_value("ar bursts", 64'(ar_total), 64'(exp_bursts));
    check_value("aw bursts", 64'(aw_cnt), 64'(exp_bursts));
    check_value("b responses", 64'(b_cnt), 64'(exp_bursts));
    check_value("w beats", 64'(w_total), 64'(total / 8));
    check_value("irq pulses", 64'(irq_cnt), 64'd1);
    check_value("pending reads at end", 64'(pend_ar), 64'd0);
    check_value("pending writes at end", 64'(pend_aw), 64'd0);
endtask

task automatic test_readback();
    logic [31:0] val;
    $display("%0t register readback", $time);
    check_value("ddr_arvalid", 64'(ddr_arvalid), 64'd0);
    check_value("pcim_awvalid", 64'(pcim_awvalid), 64'd0);
    check_value("pcim_wvalid", 64'(pcim_wvalid), 64'd0);
    check_value("s_bvalid", 64'(s_bvalid), 64'd0);
    check_value("s_rvalid", 64'(s_rvalid), 64'd0);
    check_value("irq", 64'(irq), 64'd0);
    check_value("s_awready", 64'(s_awready), 64'd1); // both channels idle
    check_value("s_arready", 64'(s_arready), 64'd1);
    check_reg(csr_base, 32'd0);
    check_reg(csr_total, 32'd0);
    check_reg(csr_start, 32'd0);
    check_reg(csr_pend_ar, 32'd1);
    check_reg(csr_pend_aw, 32'd1);
    csr_write(reg_addr(csr_base), 32'h1234_5678);
    csr_write(reg_addr(csr_total), 32'h0000_0A00);
    csr_write(reg_addr(csr_start), 32'hA5A5_A5A4); // bit 0 clear so the engine stays off
    csr_write(reg_addr(csr_pend_ar), 32'd7);
    csr_write(reg_addr(csr_pend_aw), 32'd5);
    csr_write(32'h0000_0018, 32'hDEAD_BEEF);
    check_reg(csr_base, 32'h1234_5678);
    check_reg(csr_total, 32'h0000_0A00);
    check_reg(csr_start, 32'hA5A5_A5A4);
    check_reg(csr_pend_ar, 32'd7);
    check_reg(csr_pend_aw, 32'd5);
    csr_read(32'h0000_0018, val);
    check_value("s_rdata at unused offset", 64'(val), 64'd0);
endtask

task automatic test_copy_128();
    $display("%0t copy at 128 byte payload", $time);
    run_copy(2'd0, 32'h1000_0000, 32'd1024, 1, 1);
endtask

task automatic test_outstanding();
    $display("%0t outstanding limits", $time);
    run_copy(2'd1, 32'h2000_0000, 32'd512, 1, 1);
    run_copy(2'd1, 32'h3000_0000, 32'd1024, 3, 2);
    check_that(max_ar_seen > 1 || max_aw_seen > 1, "never more than one burst in flight");
endtask

task automatic test_backpressure();
    $display("%0t back-pressure at 512 byte payload", $time);
    stall_div = 3;
    run_copy(2'd2, 32'h4000_0000, 32'd1024, 2, 2);
    stall_div = 8;
endtask

task automatic test_reserved_restart();
    $display("%0t reserved payload and restart", $time);
    csr_write(reg_addr(csr_start), 32'd0);
    max_payload <= 2'd3;
    ar_total = 0;
    irq_cnt  = 0;
    csr_write(reg_addr(csr_total), 32'd1024);
    csr_write(reg_addr(csr_start), 32'd1);
    repeat (200) @(posedge clk);
    check_value("ddr ar count", 64'(ar_total), 64'd0);
    check_value("irq pulses", 64'(irq_cnt), 64'd0);
    run_copy(2'd0, 32'h5000_0000, 32'd1024, 1, 1);
endtask

// ==== tb_wb_echo.sv ====
`default_nettype none
`include "wb_defines.svh"

module tb_wb_echo
    import wb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 50;
    localparam int TEST_BEATS  = 576; // w beats over all copy runs
    // two cycles per beat plus room for bursts, csr traffic and idle waits
    localparam int WATCHDOG_CYCLES = TEST_BEATS * 2 + 848;

    logic                    clk = 1'b0;
    logic                    rstn = 1'b0;
    logic [`WB_ADDR_W-1:0]   s_awaddr = '0;
    logic                    s_awvalid = 1'b0;
    logic                    s_awready;
    logic [31:0]             s_wdata = '0;
    logic [3:0]              s_wstrb = '0;
    logic                    s_wvalid = 1'b0;
    logic                    s_wready;
    logic [1:0]              s_bresp;
    logic                    s_bvalid;
    logic                    s_bready = 1'b0;
    logic [`WB_ADDR_W-1:0]   s_araddr = '0;
    logic                    s_arvalid = 1'b0;
    logic                    s_arready;
    logic [31:0]             s_rdata;
    logic [1:0]              s_rresp;
    logic                    s_rvalid;
    logic                    s_rready = 1'b0;
    logic [`WB_ID_W-1:0]     ddr_arid;
    logic [`WB_ADDR_W-1:0]   ddr_araddr;
    logic [7:0]              ddr_arlen;
    logic [2:0]              ddr_arsize;
    logic                    ddr_arvalid;
    logic                    ddr_arready = 1'b0;
    logic [`WB_DATA_W-1:0]   ddr_rdata = '0;
    logic                    ddr_rlast = 1'b0;
    logic                    ddr_rvalid = 1'b0;
    logic                    ddr_rready;
    logic [`WB_ID_W-1:0]     pcim_awid;
    logic [`WB_ADDR_W-1:0]   pcim_awaddr;
    logic [7:0]              pcim_awlen;
    logic [2:0]              pcim_awsize;
    logic                    pcim_awvalid;
    logic                    pcim_awready = 1'b0;
    logic [`WB_DATA_W-1:0]   pcim_wdata;
    logic [`WB_DATA_W/8-1:0] pcim_wstrb;
    logic                    pcim_wlast;
    logic                    pcim_wvalid;
    logic                    pcim_wready = 1'b0;
    logic                    pcim_bvalid = 1'b0;
    logic                    pcim_bready;
    logic [1:0]              max_payload = 2'd3; // reserved until a test picks one
    logic                    irq;

    int          checks = 0;
    int          errors = 0;
    int          stall_div = 8; // one cycle in stall_div is a gap or a wready low
    logic [39:0] ar_q [$];      // arlen and araddr of accepted reads
    logic [31:0] r_addr = '0;
    int          r_left = 0;    // beats still to send for the current read
    int          pend_ar = 0;
    int          pend_aw = 0;
    int          max_ar_seen = 0;
    int          max_aw_seen = 0;
    int          lim_ar = 1;
    int          lim_aw = 1;
    int          ar_total = 0;
    int          aw_cnt = 0;
    int          w_burst = 0;
    int          w_beat = 0;
    int          w_total = 0;
    int          b_cnt = 0;
    int          irq_cnt = 0;
    logic [31:0] exp_base = '0;
    int          exp_burst_bytes = 128;
    int          exp_bursts = 0;

    wb_echo_top dut_i (.*);

    always #HALF_PERIOD clk = ~clk;

    // ddr content at a byte address
    function automatic logic [63:0] beat_data(input logic [31:0] addr);
        return {32'h0, addr} ^ 64'hA5A5_A5A5_0000_0000;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAILED %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_that(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic finish_run(input bit timed_out);
        if (timed_out) $display("timeout: the tests did not complete in time");
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // ddr read model
    always @(posedge clk) begin
        logic [39:0] req;
        if (rstn) begin
            ddr_arready <= ($urandom % 4) != 0;
            if (ddr_arvalid && ddr_arready) begin
                check_value("ddr_araddr", 64'(ddr_araddr), 64'(ar_total * exp_burst_bytes));
                check_value("ddr_arlen", 64'(ddr_arlen), 64'(exp_burst_bytes / 8 - 1));
                check_value("ddr_arsize", 64'(ddr_arsize), 64'd3); // 8 byte beats
                check_value("ddr_arid", 64'(ddr_arid), 64'd0);
                ar_q.push_back({ddr_arlen, ddr_araddr});
                ar_total++;
                pend_ar++;
                if (pend_ar > max_ar_seen) max_ar_seen = pend_ar;
                check_that(pend_ar <= lim_ar, "outstanding reads went above the limit");
            end
            if (ddr_rvalid && ddr_rready) begin
                r_addr += 32'd8;
                r_left--;
                if (ddr_rlast) pend_ar--;
            end
            if (!ddr_rvalid || ddr_rready) begin // a beat stays until taken
                if (r_left == 0 && ar_q.size() != 0) begin
                    req = ar_q.pop_front();
                    r_addr = req[31:0];
                    r_left = int'(req[39:32]) + 1;
                end
                if (r_left != 0 && ($urandom % stall_div) != 0) begin
                    ddr_rvalid <= 1'b1;
                    ddr_rdata  <= beat_data(r_addr);
                    ddr_rlast  <= (r_left == 1);
                end else begin
                    ddr_rvalid <= 1'b0;
                end
            end
        end
    end

    // pcie write model and checker
    always @(posedge clk) begin
        if (rstn) begin
            pcim_awready <= ($urandom % 2) != 0;
            pcim_wready  <= ($urandom % stall_div) != 0;
            if (irq) begin
                irq_cnt++;
                check_value("bursts done at irq", 64'(b_cnt), 64'(exp_bursts));
            end
            if (pcim_awvalid && pcim_awready) begin
                check_value("pcim_awaddr", 64'(pcim_awaddr),
                            64'(exp_base + 32'(aw_cnt * exp_burst_bytes)));
                check_value("pcim_awlen", 64'(pcim_awlen), 64'(exp_burst_bytes / 8 - 1));
                check_value("pcim_awsize", 64'(pcim_awsize), 64'd3);
                check_value("pcim_awid", 64'(pcim_awid), 64'd0);
                aw_cnt++;
                pend_aw++;
                if (pend_aw > max_aw_seen) max_aw_seen = pend_aw;
                check_that(pend_aw <= lim_aw, "outstanding writes went above the limit");
            end
            if (pcim_wvalid && pcim_wready) begin
                check_that(w_burst < exp_bursts, "write beat after the last expected burst");
                check_value("pcim_wdata", pcim_wdata,
                            beat_data(32'(w_burst * exp_burst_bytes + w_beat * 8)));
                check_value("pcim_wlast", 64'(pcim_wlast),
                            64'(w_beat == exp_burst_bytes / 8 - 1));
                check_value("pcim_wstrb", 64'(pcim_wstrb), 64'hFF);
                w_total++;
                w_beat++;
                if (pcim_wlast) begin
                    w_burst++;
                    w_beat = 0;
                end
            end
            if (pcim_bvalid) check_value("pcim_bready", 64'(pcim_bready), 64'd1);
            if (pcim_bvalid && pcim_bready) begin
                b_cnt++;
                pend_aw--;
            end
            // b only once both aw and the last beat are in
            if (!pcim_bvalid || pcim_bready) begin
                pcim_bvalid <= b_cnt < aw_cnt && b_cnt < w_burst && ($urandom % 2) != 0;
            end
        end
    end

`include "tb_wb_tests.svh"

    initial begin
        void'($urandom(57));
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        test_readback();
        test_copy_128();
        test_outstanding();
        test_backpressure();
        test_reserved_restart();
        finish_run(1'b0);
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

// ==== wb_csr.sv ====
`default_nettype none
`include "wb_defines.svh"

module wb_csr
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [`WB_ADDR_W-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [31:0]           s_wdata,
    input  logic [3:0]            s_wstrb,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [`WB_ADDR_W-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [31:0]           s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output logic [`WB_ADDR_W-1:0] base_addr,
    output logic [31:0]           total_bytes,
    output logic                  start,
    output logic [31:0]           max_pend_ar,
    output logic [31:0]           max_pend_aw
);

    typedef enum logic [1:0] {wr_idle, wr_data, wr_resp} wr_state_t;
    typedef enum logic {rd_idle, rd_resp} rd_state_t;

    wr_state_t             wr_state;
    rd_state_t             rd_state;
    logic [`WB_ADDR_W-1:0] awaddr_q;
    logic [31:0]           rdata_q;
    logic [31:0]           regs [5];
    csr_idx_t              wr_idx;
    csr_idx_t              rd_idx;
    logic                  wr_hit;
    logic                  rd_hit;

    // offset to register index, 0 for an unknown offset
    function automatic logic decode(input logic [`WB_ADDR_W-1:0] addr, output csr_idx_t idx);
        decode = 1'b1;
        case (addr)
            `WB_CSR_BASE_ADDR:   idx = csr_base;
            `WB_CSR_TOTAL_BYTES: idx = csr_total;
            `WB_CSR_START:       idx = csr_start;
            `WB_CSR_MAX_PEND_AR: idx = csr_pend_ar;
            `WB_CSR_MAX_PEND_AW: idx = csr_pend_aw;
            default: begin
                idx    = csr_base;
                decode = 1'b0;
            end
        endcase
    endfunction

    always_comb begin
        wr_hit = decode(awaddr_q, wr_idx);
        rd_hit = decode(s_araddr, rd_idx);
    end

    // write channel, address then data then response
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: if (s_awvalid) wr_state <= wr_data;
                wr_data: if (s_wvalid) wr_state <= wr_resp;
                wr_resp: if (s_bready) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (s_awvalid && s_awready) awaddr_q <= s_awaddr;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 5; i++) begin
                regs[i] <= '0;
            end
            regs[csr_pend_ar] <= 32'd1; // at least one in flight
            regs[csr_pend_aw] <= 32'd1;
        end else if (s_wvalid && s_wready && wr_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (s_wstrb[b]) regs[wr_idx][8*b +: 8] <= s_wdata[8*b +: 8];
            end
        end
    end

    // read channel
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_state <= rd_idle;
        end else if (rd_state == rd_idle) begin
            if (s_arvalid) rd_state <= rd_resp;
        end else if (s_rready) begin
            rd_state <= rd_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready) rdata_q <= rd_hit ? regs[rd_idx] : 32'd0;
    end

    assign s_awready = (wr_state == wr_idle);
    assign s_wready  = (wr_state == wr_data);
    assign s_bvalid  = (wr_state == wr_resp);
    assign s_bresp   = 2'b00; // OKAY
    assign s_arready = (rd_state == rd_idle);
    assign s_rvalid  = (rd_state == rd_resp);
    assign s_rdata   = rdata_q;
    assign s_rresp   = 2'b00;

    assign base_addr   = regs[csr_base];
    assign total_bytes = regs[csr_total];
    assign start       = regs[csr_start][0];
    assign max_pend_ar = regs[csr_pend_ar];
    assign max_pend_aw = regs[csr_pend_aw];

    a_no_resp_during_data: assert property (@(posedge clk) disable iff (!rstn)
        !(s_bvalid && s_wready));

endmodule

`default_nettype wire

// ==== wb_defines.svh ====
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 64 // 8 bytes per beat
`define WB_ID_W   4  // ids driven to zero

// control register byte offsets
`define WB_CSR_BASE_ADDR   32'h0000_0000 // pcie base added to every write
`define WB_CSR_TOTAL_BYTES 32'h0000_0004
`define WB_CSR_START       32'h0000_0008 // bit 0 only
`define WB_CSR_MAX_PEND_AR 32'h0000_000C
`define WB_CSR_MAX_PEND_AW 32'h0000_0010

`endif

// ==== wb_echo_top.sv ====
`default_nettype none
`include "wb_defines.svh"

module wb_echo_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`WB_ADDR_W-1:0]   s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [31:0]             s_wdata,
    input  logic [3:0]              s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [`WB_ADDR_W-1:0]   s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [31:0]             s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output logic [`WB_ID_W-1:0]     ddr_arid,
    output logic [`WB_ADDR_W-1:0]   ddr_araddr,
    output logic [7:0]              ddr_arlen,
    output logic [2:0]              ddr_arsize,
    output logic                    ddr_arvalid,
    input  logic                    ddr_arready,
    input  logic [`WB_DATA_W-1:0]   ddr_rdata,
    input  logic                    ddr_rlast,
    input  logic                    ddr_rvalid,
    output logic                    ddr_rready,
    output logic [`WB_ID_W-1:0]     pcim_awid,
    output logic [`WB_ADDR_W-1:0]   pcim_awaddr,
    output logic [7:0]              pcim_awlen,
    output logic [2:0]              pcim_awsize,
    output logic                    pcim_awvalid,
    input  logic                    pcim_awready,
    output logic [`WB_DATA_W-1:0]   pcim_wdata,
    output logic [`WB_DATA_W/8-1:0] pcim_wstrb,
    output logic                    pcim_wlast,
    output logic                    pcim_wvalid,
    input  logic                    pcim_wready,
    input  logic                    pcim_bvalid,
    output logic                    pcim_bready,
    input  logic [1:0]              max_payload,
    output logic                    irq
);

    // csr values
    logic [`WB_ADDR_W-1:0] base_addr;
    logic [31:0]           total_bytes;
    logic                  start;
    logic [31:0]           max_pend_ar;
    logic [31:0]           max_pend_aw;

    // flow control to issuer
    logic                  issue;
    logic [7:0]            burst_len;
    logic                  restart;

    // handshakes seen by flow control
    logic                  ar_fire;
    logic                  r_last_fire;
    logic                  aw_fire;
    logic                  b_fire;

    assign ar_fire     = ddr_arvalid && ddr_arready;
    assign r_last_fire = ddr_rvalid && ddr_rready && ddr_rlast;
    assign aw_fire     = pcim_awvalid && pcim_awready;
    assign b_fire      = pcim_bvalid && pcim_bready;

    assign ddr_arid  = '0; // single id
    assign pcim_awid = '0;

    wb_csr u_csr (.*);

    wb_flow_ctrl u_flow_ctrl (.*);

    wb_r2w u_r2w (.*);

endmodule

`default_nettype wire

// ==== wb_flow_ctrl.sv ====
`default_nettype none

module wb_flow_ctrl
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic [1:0]  max_payload,
    input  logic [31:0] total_bytes,
    input  logic        start,
    input  logic [31:0] max_pend_ar,
    input  logic [31:0] max_pend_aw,
    input  logic        ar_fire,
    input  logic        r_last_fire,
    input  logic        aw_fire,
    input  logic        b_fire,
    output logic        issue,
    output logic [7:0]  burst_len,
    output logic        restart,
    output logic        irq
);

    logic [31:0] burst_bytes;
    logic        rsvd;
    logic        start_q;
    logic [31:0] pend_ar;
    logic [31:0] pend_aw;
    logic [31:0] issued_bytes;
    logic [31:0] done_bytes;
    logic        irq_done;

    // payload code to beats and bytes
    always_comb begin
        rsvd        = 1'b0;
        burst_len   = 8'd0;
        burst_bytes = 32'd0;
        case (max_payload_t'(max_payload))
            mps_128: begin
                burst_len   = 8'd15;
                burst_bytes = 32'd128;
            end
            mps_256: begin
                burst_len   = 8'd31;
                burst_bytes = 32'd256;
            end
            mps_512: begin
                burst_len   = 8'd63;
                burst_bytes = 32'd512;
            end
            default: rsvd = 1'b1; // nothing issued
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) start_q <= 1'b0;
        else start_q <= start;
    end

    assign restart = start && !start_q;

    always_ff @(posedge clk) begin
        if (!rstn || restart) begin
            pend_ar      <= '0;
            pend_aw      <= '0;
            issued_bytes <= '0;
            done_bytes   <= '0;
        end else begin
            pend_ar <= pend_ar + 32'(ar_fire) - 32'(r_last_fire); // ar until last r
            pend_aw <= pend_aw + 32'(aw_fire) - 32'(b_fire);      // aw until b
            if (ar_fire) issued_bytes <= issued_bytes + burst_bytes;
            if (b_fire) done_bytes <= done_bytes + burst_bytes;
        end
    end

    assign issue = start && !restart && !rsvd && (issued_bytes < total_bytes) &&
                   (pend_ar < max_pend_ar) && (pend_aw < max_pend_aw);

    // one pulse per start
    always_ff @(posedge clk) begin
        if (!rstn || restart) begin
            irq      <= 1'b0;
            irq_done <= 1'b0;
        end else begin
            irq <= 1'b0;
            if (start && !irq_done && done_bytes >= total_bytes) begin
                irq      <= 1'b1;
                irq_done <= 1'b1;
            end
        end
    end

    a_pend_limit: assert property (@(posedge clk) disable iff (!rstn)
        pend_ar <= max_pend_ar && pend_aw <= max_pend_aw);
    a_pend_ar_underflow: assert property (@(posedge clk) disable iff (!rstn)
        r_last_fire && !ar_fire |-> pend_ar != 0);
    a_pend_aw_underflow: assert property (@(posedge clk) disable iff (!rstn)
        b_fire && !aw_fire |-> pend_aw != 0);
    a_irq_pulse: assert property (@(posedge clk) disable iff (!rstn)
        irq |=> !irq);

endmodule

`default_nettype wire

// ==== wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // register index, byte offset is index * 4
    typedef enum logic [2:0] {
        csr_base    = 3'd0,
        csr_total   = 3'd1,
        csr_start   = 3'd2,
        csr_pend_ar = 3'd3,
        csr_pend_aw = 3'd4
    } csr_idx_t;

    // pcie max payload code
    typedef enum logic [1:0] {
        mps_128  = 2'd0, // 16 beats
        mps_256  = 2'd1, // 32 beats
        mps_512  = 2'd2, // 64 beats
        mps_rsvd = 2'd3
    } max_payload_t;

    // burst issuer states
    typedef enum logic [1:0] {
        st_idle,
        st_issue_both,
        st_issue_ar, // aw already taken
        st_issue_aw  // ar already taken
    } r2w_state_t;

endpackage

`default_nettype wire

// ==== wb_r2w.sv ====
`default_nettype none
`include "wb_defines.svh"

module wb_r2w
    import wb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    issue,
    input  logic [7:0]              burst_len,
    input  logic                    restart,
    input  logic [`WB_ADDR_W-1:0]   base_addr,
    output logic [`WB_ADDR_W-1:0]   ddr_araddr,
    output logic [7:0]              ddr_arlen,
    output logic [2:0]              ddr_arsize,
    output logic                    ddr_arvalid,
    input  logic                    ddr_arready,
    input  logic [`WB_DATA_W-1:0]   ddr_rdata,
    input  logic                    ddr_rlast,
    input  logic                    ddr_rvalid,
    output logic                    ddr_rready,
    output logic [`WB_ADDR_W-1:0]   pcim_awaddr,
    output logic [7:0]              pcim_awlen,
    output logic [2:0]              pcim_awsize,
    output logic                    pcim_awvalid,
    input  logic                    pcim_awready,
    output logic [`WB_DATA_W-1:0]   pcim_wdata,
    output logic [`WB_DATA_W/8-1:0] pcim_wstrb,
    output logic                    pcim_wlast,
    output logic                    pcim_wvalid,
    input  logic                    pcim_wready,
    input  logic                    pcim_bvalid,
    output logic                    pcim_bready
);

    localparam int BEAT_BYTES = `WB_DATA_W / 8;

    r2w_state_t            state;
    r2w_state_t            state_nxt;
    logic [`WB_ADDR_W-1:0] offset;
    logic [7:0]            len_q;
    logic [7:0]            b_owed;
    logic                  ar_fire;
    logic                  aw_fire;

    assign ar_fire = ddr_arvalid && ddr_arready;
    assign aw_fire = pcim_awvalid && pcim_awready;

    // ar and aw go out together, either may be taken first
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (issue) state_nxt = st_issue_both;
            st_issue_both: begin
                if (ar_fire && aw_fire) state_nxt = st_idle;
                else if (aw_fire) state_nxt = st_issue_ar;
                else if (ar_fire) state_nxt = st_issue_aw;
            end
            st_issue_ar: if (ar_fire) state_nxt = st_idle;
            st_issue_aw: if (aw_fire) state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) state <= st_idle;
        else state <= state_nxt;
    end

    // len held stable while a burst is requested
    always_ff @(posedge clk) begin
        if (state == st_idle && issue) len_q <= burst_len;
    end

    always_ff @(posedge clk) begin
        if (!rstn || restart) begin
            offset <= '0;
        end else if (state != st_idle && state_nxt == st_idle) begin
            offset <= offset + `WB_ADDR_W'((32'(len_q) + 32'd1) * BEAT_BYTES);
        end
    end

    assign ddr_araddr   = offset;
    assign ddr_arlen    = len_q;
    assign ddr_arsize   = 3'($clog2(BEAT_BYTES));
    assign ddr_arvalid  = (state == st_issue_both) || (state == st_issue_ar);
    assign pcim_awaddr  = base_addr + offset;
    assign pcim_awlen   = len_q;
    assign pcim_awsize  = 3'($clog2(BEAT_BYTES));
    assign pcim_awvalid = (state == st_issue_both) || (state == st_issue_aw);

    // r beats straight through to w
    assign pcim_wdata  = ddr_rdata;
    assign pcim_wstrb  = '1;
    assign pcim_wlast  = ddr_rlast;
    assign pcim_wvalid = ddr_rvalid;
    assign ddr_rready  = pcim_wready;
    assign pcim_bready = 1'b1;

    // bursts whose last beat went out and whose b is still due
    always_ff @(posedge clk) begin
        if (!rstn) begin
            b_owed <= '0;
        end else begin
            b_owed <= b_owed + 8'(pcim_wvalid && pcim_wready && pcim_wlast)
                      - 8'(pcim_bvalid);
        end
    end

    a_addr_match: assert property (@(posedge clk) disable iff (!rstn)
        (ddr_arvalid || pcim_awvalid) |-> pcim_awaddr == base_addr + ddr_araddr);
    a_b_after_data: assert property (@(posedge clk) disable iff (!rstn)
        pcim_bvalid |-> b_owed != 0);

endmodule

`default_nettype wire
